// ==== rtl/chroma_sse_top.sv ====
// Chroma SSE top level joining the row loader and the SSE engine
`default_nettype none

module chroma_sse_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    // Row stream in
    input  wire logic                 row_valid,
    output logic                      row_ready,
    input  wire sse_pkg::row_pair_t   row_data,

    // Result stream out
    output logic                      res_valid,
    input  wire logic                 res_ready,
    output sse_pkg::sse_result_t      res_data
);

    // --------------------------------------------------
    // Loader to engine handoff
    // --------------------------------------------------

    logic            blk_valid;
    logic            blk_ready;
    sse_pkg::block_t blk_data;

    // --------------------------------------------------
    // Instances
    // --------------------------------------------------

    row_loader u_row_loader (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_valid (row_valid),
        .row_ready (row_ready),
        .row_data  (row_data),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .blk_data  (blk_data)
    );

    // Takes a block only when idle, so the loader can refill meanwhile
    sse_engine u_sse_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .blk_data  (blk_data),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data)
    );

endmodule

`default_nettype wire

// ==== rtl/row_loader.sv ====
// Row loader that gathers a stream of row pairs into one full block
`default_nettype none

module row_loader (
    input  wire logic                clk,
    input  wire logic                rst_n,

    // Row stream in
    input  wire logic                row_valid,
    output logic                     row_ready,
    input  wire sse_pkg::row_pair_t  row_data,

    // Block handoff to the engine
    output logic                     blk_valid,
    input  wire logic                blk_ready,
    output sse_pkg::block_t          blk_data
);

    // --------------------------------------------------
    // State
    // --------------------------------------------------

    logic [sse_pkg::ROW_CNT_W-1:0] row_cnt;
    logic                          full;
    sse_pkg::block_t               blk_reg;

    logic                          row_take;
    logic                          blk_take;

    assign row_take = row_valid & row_ready;
    assign blk_take = full & blk_ready;

    // --------------------------------------------------
    // Row counter and full flag
    // --------------------------------------------------

    // Gaps in row_valid just pause the count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (row_take) begin
            if (row_cnt == sse_pkg::LAST_ROW) begin
                row_cnt <= '0;
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // Set on the last row, cleared when the engine copies the block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (row_take && row_cnt == sse_pkg::LAST_ROW) begin
            full <= 1'b1;
        end else if (blk_take) begin
            full <= 1'b0;
        end
    end

    // --------------------------------------------------
    // Block storage
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (row_take) begin
            blk_reg.rows[row_cnt] <= row_data;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------

    // Stall the row stream while a finished block waits
    assign row_ready = ~full;

    assign blk_valid = full;
    assign blk_data  = blk_reg;

endmodule

`default_nettype wire

// ==== rtl/square_rom.sv ====
// Registered square table for a signed chroma difference
`default_nettype none

module square_rom (
    input  wire logic                                clk,
    input  wire logic                                en,
    input  wire logic signed [sse_pkg::DIFF_W-1:0]   addr,
    output logic             [sse_pkg::SQ_W-1:0]     square
);

    logic [sse_pkg::SQ_W-1:0] sq_table [sse_pkg::ROM_DEPTH];

    // Table fill
    // Entry i holds the square of i read as a signed code
    initial begin
        logic signed [sse_pkg::DIFF_W-1:0] code;
        logic        [2*sse_pkg::DIFF_W-1:0] prod;
        for (int i = 0; i < sse_pkg::ROM_DEPTH; i++) begin
            code = sse_pkg::DIFF_W'(i);
            prod = code * code;
            // Only -256 overflows, and a real difference never reaches it
            if (prod[2*sse_pkg::DIFF_W-1:sse_pkg::SQ_W] != '0) begin
                sq_table[i] = '1;
            end else begin
                sq_table[i] = prod[sse_pkg::SQ_W-1:0];
            end
        end
    end

    // Synchronous read, output holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            square <= sq_table[$unsigned(addr)];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sse_engine.sv ====
// SSE engine with row sequencing, difference stage, square ROM lanes and U/V sums
`default_nettype none

module sse_engine (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    // Block from the loader
    input  wire logic                 blk_valid,
    output logic                      blk_ready,
    input  wire sse_pkg::block_t      blk_data,

    // Result stream out
    output logic                      res_valid,
    input  wire logic                 res_ready,
    output sse_pkg::sse_result_t      res_data
);

    sse_pkg::engine_state_e        state;
    logic [sse_pkg::ROW_CNT_W-1:0] row_cnt;
    logic                          blk_accept;

    // Working copy and the row picked from it
    sse_pkg::block_t               work_blk;
    sse_pkg::row_pair_t            sel_row;

    // Stage enables: row picked, diff registered, ROM output ready
    logic                          row_vld;
    logic                          diff_vld;
    logic                          rom_vld;

    logic signed [sse_pkg::DIFF_W-1:0] diff [sse_pkg::ROW_SAMPLES];
    logic        [sse_pkg::SQ_W-1:0]   sq   [sse_pkg::ROW_SAMPLES];

    logic [sse_pkg::SSE_W-1:0]     sum_u;
    logic [sse_pkg::SSE_W-1:0]     sum_v;
    sse_pkg::sse_result_t          acc;

    assign blk_ready  = (state == sse_pkg::IDLE);
    assign blk_accept = blk_valid & blk_ready;

    // --------------------------------------------------
    // FSM and row counter
    // --------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= sse_pkg::IDLE;
            row_cnt   <= '0;
            res_valid <= 1'b0;
        end else begin
            case (state)
                sse_pkg::IDLE: begin
                    if (blk_valid) begin
                        state   <= sse_pkg::RUN;
                        row_cnt <= '0;
                    end
                end
                sse_pkg::RUN: begin
                    row_cnt <= row_cnt + 1'b1;
                    if (row_cnt == sse_pkg::LAST_ROW) begin
                        state <= sse_pkg::DRAIN;
                    end
                end
                sse_pkg::DRAIN: begin
                    // Last ROM row reaches the accumulators on this edge
                    if (rom_vld && !diff_vld) begin
                        state     <= sse_pkg::HOLD;
                        res_valid <= 1'b1;
                    end
                end
                sse_pkg::HOLD: begin
                    if (res_ready) begin
                        state     <= sse_pkg::IDLE;
                        res_valid <= 1'b0;
                    end
                end
                default: begin
                    state <= sse_pkg::IDLE;
                end
            endcase
        end
    end

    // Enable chain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_vld  <= 1'b0;
            diff_vld <= 1'b0;
            rom_vld  <= 1'b0;
        end else begin
            row_vld  <= (state == sse_pkg::RUN);
            diff_vld <= row_vld;
            rom_vld  <= diff_vld;
        end
    end

    // --------------------------------------------------
    // Working copy and row select
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (blk_accept) begin
            work_blk <= blk_data;
        end
    end

    always_ff @(posedge clk) begin
        if (state == sse_pkg::RUN) begin
            sel_row <= work_blk.rows[row_cnt];
        end
    end

    // --------------------------------------------------
    // Difference stage and square lanes
    // --------------------------------------------------

    for (genvar g = 0; g < sse_pkg::ROW_SAMPLES; g++) begin : g_lane
        // Zero-extend both samples so the difference keeps its sign
        always_ff @(posedge clk) begin
            if (row_vld) begin
                diff[g] <= $signed({1'b0, sel_row.orig[g]}) -
                           $signed({1'b0, sel_row.recon[g]});
            end
        end

        square_rom u_square_rom (
            .clk    (clk),
            .en     (diff_vld),
            .addr   (diff[g]),
            .square (sq[g])
        );
    end

    // --------------------------------------------------
    // Plane sums and accumulators
    // --------------------------------------------------

    // Lanes 0..7 feed U, lanes 8..15 feed V
    always_comb begin
        sum_u = '0;
        sum_v = '0;
        for (int i = 0; i < sse_pkg::PLANE_SAMPLES; i++) begin
            sum_u = sum_u + sse_pkg::SSE_W'(sq[i]);
            sum_v = sum_v + sse_pkg::SSE_W'(sq[i + sse_pkg::PLANE_SAMPLES]);
        end
    end

    // Cleared on accept, frozen through DRAIN end and HOLD
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (blk_accept) begin
            acc <= '0;
        end else if (rom_vld) begin
            acc.sse_u     <= acc.sse_u + sum_u;
            acc.sse_v     <= acc.sse_v + sum_v;
            acc.sse_total <= acc.sse_total + sum_u + sum_v;
        end
    end

    assign res_data = acc;

endmodule

`default_nettype wire

// ==== rtl/sse_pkg.sv ====
// Chroma SSE sizes, row/block/result structs and engine state enum
`default_nettype none

package sse_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------

    // One chroma sample
    localparam int SAMPLE_W = 8;

    // Samples per row, U half then V half
    localparam int ROW_SAMPLES = 16;
    localparam int PLANE_SAMPLES = 8;

    // Rows per block
    localparam int BLOCK_ROWS = 8;
    localparam int ROW_CNT_W = $clog2(BLOCK_ROWS);
    localparam logic [ROW_CNT_W-1:0] LAST_ROW = ROW_CNT_W'(BLOCK_ROWS - 1);

    // Signed difference covers -255 .. 255
    localparam int DIFF_W = SAMPLE_W + 1;

    // Square of the largest difference is 65025
    localparam int SQ_W = 16;

    // Square table depth, one entry per difference code
    localparam int ROM_DEPTH = 1 << DIFF_W;

    // Width of each accumulated sum
    localparam int SSE_W = 32;

    // --------------------------------------------------
    // Data types
    // --------------------------------------------------

    // Sample 0 sits in the low byte; samples 0..7 are U, 8..15 are V
    typedef struct packed {
        logic [ROW_SAMPLES-1:0][SAMPLE_W-1:0] orig;
        logic [ROW_SAMPLES-1:0][SAMPLE_W-1:0] recon;
    } row_pair_t;

    // Row 0 sits in the low bits
    typedef struct packed {
        row_pair_t [BLOCK_ROWS-1:0] rows;
    } block_t;

    typedef struct packed {
        logic [SSE_W-1:0] sse_u;
        logic [SSE_W-1:0] sse_v;
        logic [SSE_W-1:0] sse_total;
    } sse_result_t;

    // --------------------------------------------------
    // Engine FSM
    // --------------------------------------------------

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        HOLD
    } engine_state_e;

endpackage

`default_nettype wire

// ==== sim/tb_chroma_sse_tasks.svh ====
// Row driving, result collection, compare tasks and directed tests for the chroma SSE testbench
`ifndef TB_CHROMA_SSE_TASKS_SVH
`define TB_CHROMA_SSE_TASKS_SVH

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------

task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED at %0d ns: %s expected %0d, actual %0d", $time, name, exp, act);
    abort_run();
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        report_mismatch(name, 32'(exp), 32'(act));
    end
endtask

task automatic compare_result(input string name, input sse_pkg::sse_result_t exp,
                              input sse_pkg::sse_result_t act);
    if (act.sse_u !== exp.sse_u) begin
        report_mismatch({name, ".sse_u"}, exp.sse_u, act.sse_u);
    end else if (act.sse_v !== exp.sse_v) begin
        report_mismatch({name, ".sse_v"}, exp.sse_v, act.sse_v);
    end else if (act.sse_total !== exp.sse_total) begin
        report_mismatch({name, ".sse_total"}, exp.sse_total, act.sse_total);
    end
endtask

// --------------------------------------------------
// Stimulus and collection
// --------------------------------------------------

task automatic random_block(output sse_pkg::block_t blk);
    for (int r = 0; r < sse_pkg::BLOCK_ROWS; r++) begin
        for (int s = 0; s < sse_pkg::ROW_SAMPLES; s++) begin
            blk.rows[r].orig[s]  = sse_pkg::SAMPLE_W'($urandom);
            blk.rows[r].recon[s] = sse_pkg::SAMPLE_W'($urandom);
        end
    end
endtask

task automatic queue_block(input sse_pkg::block_t blk);
    sse_pkg::sse_result_t exp;
    model_sse(blk, exp);
    tx_q.push_back(blk);
    exp_q.push_back(exp);
endtask

// Starts and ends on a falling edge; optional idle gaps between rows
task automatic send_blocks(input bit gaps);
    sse_pkg::block_t blk;
    while (tx_q.size() > 0) begin
        blk = tx_q.pop_front();
        for (int r = 0; r < sse_pkg::BLOCK_ROWS; r++) begin
            row_valid = 1'b1;
            row_data  = blk.rows[r];
            while (!row_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
            if (gaps) begin
                row_valid = 1'b0;
                repeat ($urandom_range(0, 2)) @(negedge clk);
            end
        end
    end
    row_valid = 1'b0;
endtask

// A result seen here is taken on the next rising edge
task automatic collect_results(input int count);
    int got;
    got = 0;
    res_ready = 1'b1;
    while (got < count) begin
        if (res_valid) begin
            compare_result("res_data", exp_q.pop_front(), res_data);
            got++;
        end
        @(negedge clk);
    end
endtask

task automatic hold_and_check(input int base_rows, input int cycles);
    sse_pkg::sse_result_t first_exp;
    while (!res_valid) begin
        @(negedge clk);
    end
    first_exp = exp_q[0];
    compare_result("res_data", first_exp, res_data);
    repeat (cycles) begin
        @(negedge clk);
        compare_bit("res_valid", 1'b1, res_valid);
        compare_result("res_data", first_exp, res_data);
    end
    compare_bit("row_ready", 1'b0, row_ready);
    compare_bit("third_block_open", 1'b1,
                rows_taken < base_rows + HELD_BLOCKS * sse_pkg::BLOCK_ROWS);
endtask

// --------------------------------------------------
// Directed tests
// --------------------------------------------------

task automatic reset_outputs_idle();
    compare_bit("row_ready", 1'b1, row_ready);
    compare_bit("res_valid", 1'b0, res_valid);
endtask

task automatic identical_block_zero();
    sse_pkg::block_t blk;
    random_block(blk);
    for (int r = 0; r < sse_pkg::BLOCK_ROWS; r++) begin
        blk.rows[r].recon = blk.rows[r].orig;
    end
    tx_q.push_back(blk);
    exp_q.push_back('0);
    fork
        send_blocks(1'b0);
        collect_results(1);
    join
endtask

// Each of 64 samples per plane off by 255
task automatic full_scale_block();
    sse_pkg::block_t      blk;
    sse_pkg::sse_result_t exp;
    for (int r = 0; r < sse_pkg::BLOCK_ROWS; r++) begin
        blk.rows[r].orig  = '1;
        blk.rows[r].recon = '0;
    end
    exp.sse_u     = 32'd4161600;
    exp.sse_v     = 32'd4161600;
    exp.sse_total = 32'd8323200;
    tx_q.push_back(blk);
    exp_q.push_back(exp);
    fork
        send_blocks(1'b0);
        collect_results(1);
    join
endtask

task automatic back_to_back_stream();
    sse_pkg::block_t blk;
    repeat (RANDOM_BLOCKS) begin
        random_block(blk);
        queue_block(blk);
    end
    fork
        send_blocks(1'b0);
        collect_results(RANDOM_BLOCKS);
    join
endtask

task automatic gapped_stream();
    sse_pkg::block_t blk;
    repeat (GAPPED_BLOCKS) begin
        random_block(blk);
        queue_block(blk);
    end
    fork
        send_blocks(1'b1);
        collect_results(GAPPED_BLOCKS);
    join
endtask

task automatic held_result_back_pressure();
    sse_pkg::block_t blk;
    int              base_rows;
    base_rows = rows_taken;
    repeat (HELD_BLOCKS) begin
        random_block(blk);
        queue_block(blk);
    end
    res_ready = 1'b0;
    fork
        send_blocks(1'b0);
        begin
            hold_and_check(base_rows, 30);
            collect_results(HELD_BLOCKS);
        end
    join
endtask

`endif

// ==== sim/tb_chroma_sse.sv ====
// Chroma SSE testbench with clock, reset, DUT, reference model, timeout and test sequence
`default_nettype none

module tb_chroma_sse;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RANDOM_BLOCKS = 20;
    localparam int GAPPED_BLOCKS = 10;
    localparam int HELD_BLOCKS   = 3;
    localparam int TOTAL_BLOCKS  = 2 + RANDOM_BLOCKS + GAPPED_BLOCKS + HELD_BLOCKS;
    localparam int TOTAL_ROWS    = TOTAL_BLOCKS * sse_pkg::BLOCK_ROWS;
    localparam int CYCLE_LIMIT   = TOTAL_ROWS * 4 + 200;

    logic                 clk;
    logic                 rst_n;
    logic                 row_valid;
    logic                 row_ready;
    sse_pkg::row_pair_t   row_data;
    logic                 res_valid;
    logic                 res_ready;
    sse_pkg::sse_result_t res_data;

    // Blocks still to send and results still to arrive
    sse_pkg::block_t      tx_q[$];
    sse_pkg::sse_result_t exp_q[$];

    int                   cycle_cnt = 0;
    int                   rows_taken = 0;

    chroma_sse_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_valid (row_valid),
        .row_ready (row_ready),
        .row_data  (row_data),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // Cycle counter, row count and timeout
    // --------------------------------------------------

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (row_valid && row_ready) begin
            rows_taken <= rows_taken + 1;
        end
    end

    always @(negedge clk) begin
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "Run stopped at %0d ns", $time);
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Squared differences summed per plane over all rows
    task automatic model_sse(input sse_pkg::block_t blk, output sse_pkg::sse_result_t res);
        int d;
        res = '0;
        for (int r = 0; r < sse_pkg::BLOCK_ROWS; r++) begin
            for (int s = 0; s < sse_pkg::ROW_SAMPLES; s++) begin
                d = int'(blk.rows[r].orig[s]) - int'(blk.rows[r].recon[s]);
                if (s < sse_pkg::PLANE_SAMPLES) begin
                    res.sse_u = res.sse_u + d * d;
                end else begin
                    res.sse_v = res.sse_v + d * d;
                end
            end
        end
        res.sse_total = res.sse_u + res.sse_v;
    endtask

    `include "tb_chroma_sse_tasks.svh"

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        void'($urandom(32'hc246));
        rst_n     = 1'b0;
        row_valid = 1'b0;
        row_data  = '0;
        res_ready = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        reset_outputs_idle();
        identical_block_zero();
        full_scale_block();
        back_to_back_stream();
        gapped_stream();
        held_result_back_pressure();

        repeat (4) @(negedge clk);
        if (exp_q.size() == 0 && !res_valid) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Run ended with %0d results never delivered", exp_q.size());
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+sim
rtl/sse_pkg.sv
rtl/square_rom.sv
rtl/row_loader.sv
rtl/sse_engine.sv
rtl/chroma_sse_top.sv
sim/tb_chroma_sse.sv
